//--- Makefile
# Verilator build and run of the RP drive testbench

LOG = sim.log

.PHONY: simulate clean

simulate:
	verilator --binary --assert --top-module rpDriveTb -f tb.f -o rpDriveSim
	./obj_dir/rpDriveSim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/rpDriveTb.sv
//////////////////////////////////////////////////
// RP drive register file testbench
// LFSR driven host writes and media pulses,
// checked against a cycle model of the drive
//////////////////////////////////////////////////

module rpDriveTb;

   localparam logic [5:0]  lastSect     = 6'(rpPkg::rpDefLastSect);
   localparam logic [5:0]  lastTrack    = 6'(rpPkg::rpDefLastTrack);
   localparam logic [9:0]  lastCyl      = 10'(rpPkg::rpDefLastCyl);
   localparam int          readyTimeout = 50;
   localparam logic [31:0] lfsrSeed     = 32'h3dda2e04;

   logic                          clk;
   logic                          rst;
   logic                          clr;
   logic                          wrStrobe;
   rpPkg::rpRegSel_e              wrSel;
   logic [rpPkg::rpDataWidth-1:0] wrData;
   rpPkg::rpRegSel_e              rdSel;
   logic [15:0]                   rdData;
   logic                          sectorDone;

   logic [31:0] lfsr;
   int          errors;
   int          timeouts;
   int          i;

   // Model state
   logic [5:0]        mSect;
   logic [5:0]        mTrack;
   logic [9:0]        mCyl;
   logic              mBusy;
   logic [7:0]        mCount;
   logic              mLastErr;
   logic              mOpErr;
   logic              mPresetPend;
   // Model scratch, one edge worth
   rpPkg::rpOpcode_e  mOp;
   logic              isCmd;
   logic              isRd;
   logic              badRd;
   logic              inc;
   logic              carry;
   logic              ovf;

   rpDrive u_rpDrive (
      .clk        (clk),
      .rst        (rst),
      .clr        (clr),
      .wrStrobe   (wrStrobe),
      .wrSel      (wrSel),
      .wrData     (wrData),
      .rdSel      (rdSel),
      .rdData     (rdData),
      .sectorDone (sectorDone)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   //////////////////////////////////////////////////
   // Reference model, one step per rising edge
   //////////////////////////////////////////////////

   always @(posedge clk or posedge rst)
   begin
      if (rst | clr)
      begin
         {mSect, mTrack, mCyl, mCount} = '0;
         {mBusy, mLastErr, mOpErr, mPresetPend} = '0;
      end
      else
      begin
         mOp   = rpPkg::rpOpcode_e'(wrData[9:8]);
         isCmd = wrStrobe && (wrSel == rpPkg::RPCS);
         isRd  = isCmd && (mOp == rpPkg::READ);
         badRd = isRd && (mBusy || (wrData[7:0] == 8'd0));
         inc   = sectorDone && mBusy;
         carry = 1'b0;
         ovf   = 1'b0;
         // Sector and track: preset, then host load, then count
         if (mPresetPend)
         begin
            mSect  = '0;
            mTrack = '0;
         end
         else if (wrStrobe && (wrSel == rpPkg::RPDA) && !mBusy)
         begin
            mSect  = wrData[5:0];
            mTrack = wrData[13:8];
         end
         else if (inc)
         begin
            if (mSect == lastSect)
            begin
               mSect = '0;
               if (mTrack == lastTrack)
               begin
                  mTrack = '0;
                  carry  = 1'b1;
               end
               else
                  mTrack = mTrack + 6'd1;
            end
            else
               mSect = mSect + 6'd1;
         end
         // Cylinder
         if (mPresetPend)
            mCyl = '0;
         else if (wrStrobe && (wrSel == rpPkg::RPDC) && !mBusy)
            mCyl = wrData[9:0];
         else if (carry)
         begin
            ovf  = (mCyl == lastCyl);
            mCyl = ovf ? 10'd0 : mCyl + 10'd1;
         end
         // Transfer state and remaining count
         if (isRd && !badRd)
         begin
            mBusy  = 1'b1;
            mCount = wrData[7:0];
         end
         else if (inc)
         begin
            mCount = mCount - 8'd1;
            if (mCount == 8'd0)
               mBusy = 1'b0;
         end
         // Error bits
         if (isCmd && (mOp == rpPkg::DRIVECLEAR))
         begin
            mLastErr = 1'b0;
            mOpErr   = 1'b0;
         end
         else
         begin
            if (ovf)
               mLastErr = 1'b1;
            if (badRd)
               mOpErr = 1'b1;
         end
         mPresetPend = isCmd && (mOp == rpPkg::PRESET);
      end
   end

   // Expected register read, reference bus layout
   function automatic logic [15:0] expectedRead(input rpPkg::rpRegSel_e sel);
      case (sel)
         rpPkg::RPDA: return {2'b00, mTrack, 2'b00, mSect};
         rpPkg::RPDC: return {6'd0, mCyl};
         rpPkg::RPDS: return {12'd0, ~mBusy, mBusy, mLastErr, mOpErr};
         default:     return 16'd0;
      endcase
   endfunction

   //////////////////////////////////////////////////
   // Random numbers
   //////////////////////////////////////////////////

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] val;
      int          k;
      val = '0;
      for (k = 0; k < n; k++)
      begin
         lfsr = lfsrStep(lfsr);
         val  = {val[30:0], lfsr[0]};
      end
      return val;
   endfunction

   function automatic logic [rpPkg::rpDataWidth-1:0] randWord();
      logic [31:0] lo;
      logic [31:0] hi;
      lo = randBits(32);
      hi = randBits(4);
      return {hi[3:0], lo};
   endfunction

   function automatic logic [rpPkg::rpDataWidth-1:0] cmdWord(input rpPkg::rpOpcode_e op,
                                                              input int cnt);
      return {26'd0, op, 8'(cnt)};
   endfunction

   //////////////////////////////////////////////////
   // Bus drivers and checks
   //////////////////////////////////////////////////

   task automatic driveIdle();
      wrStrobe   = 1'b0;
      sectorDone = 1'b0;
      clr        = 1'b0;
   endtask

   task automatic idleCycle();
      @(negedge clk);
      driveIdle();
   endtask

   task automatic writeReg(input rpPkg::rpRegSel_e sel,
                           input logic [rpPkg::rpDataWidth-1:0] data);
      @(negedge clk);
      driveIdle();
      wrStrobe = 1'b1;
      wrSel    = sel;
      wrData   = data;
   endtask

   task automatic pulseSector();
      @(negedge clk);
      driveIdle();
      sectorDone = 1'b1;
   endtask

   task automatic clrPulse();
      @(negedge clk);
      driveIdle();
      clr = 1'b1;
   endtask

   task automatic checkValue(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("** Error %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic readCheck(input rpPkg::rpRegSel_e sel);
      @(negedge clk);
      driveIdle();
      rdSel = sel;
      #1;
      checkValue(sel.name(), rdData, expectedRead(sel));
   endtask

   task automatic checkAll();
      readCheck(rpPkg::RPDA);
      readCheck(rpPkg::RPDC);
      readCheck(rpPkg::RPDS);
      readCheck(rpPkg::RPCS);
   endtask

   task automatic setAddress(input int s, input int t, input int c);
      writeReg(rpPkg::RPDA, {22'd0, 6'(t), 2'b00, 6'(s)});
      writeReg(rpPkg::RPDC, {26'd0, 10'(c)});
   endtask

   // Media pulses with random gaps of up to three cycles
   task automatic pulses(input int n);
      int k;
      int gap;
      for (k = 0; k < n; k++)
      begin
         gap = int'(randBits(2));
         repeat (gap) idleCycle();
         pulseSector();
      end
   endtask

   task automatic finishRun();
      $display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
      if ((errors == 0) && (timeouts == 0))
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   endtask

   // Poll the status ready bit
   task automatic waitReady();
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && (n < readyTimeout))
      begin
         @(negedge clk);
         driveIdle();
         rdSel = rpPkg::RPDS;
         #1;
         seen = rdData[3];
         n++;
      end
      if (!seen)
      begin
         timeouts++;
         $display("Timeout: ready never returned within %0d cycles", readyTimeout);
         finishRun();
      end
   endtask

   task automatic runRead(input int cnt);
      writeReg(rpPkg::RPCS, cmdWord(rpPkg::READ, cnt));
      pulses(cnt);
      waitReady();
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial
   begin
      lfsr     = lfsrSeed;
      errors   = 0;
      timeouts = 0;
      rst      = 1'b1;
      wrSel    = rpPkg::RPCS;
      wrData   = '0;
      rdSel    = rpPkg::RPCS;
      driveIdle();
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      checkAll();

      // Idle writes with full width data, stray pulses dropped
      for (i = 0; i < 16; i++)
      begin
         writeReg(rpPkg::RPDA, randWord());
         writeReg(rpPkg::RPDC, randWord());
         writeReg(rpPkg::RPDS, randWord());
         pulseSector();
         checkAll();
      end

      // Random transfers from legal start addresses
      for (i = 0; i < 8; i++)
      begin
         setAddress(int'(randBits(8) % 22), int'(randBits(8) % 19), int'(randBits(10) % 411));
         runRead(int'(randBits(6)) + 1);
         checkAll();
      end

      // Busy drive ignores address writes and a second READ
      setAddress(5, 3, 100);
      writeReg(rpPkg::RPCS, cmdWord(rpPkg::READ, 8));
      pulses(3);
      writeReg(rpPkg::RPDA, randWord());
      writeReg(rpPkg::RPDC, randWord());
      writeReg(rpPkg::RPCS, cmdWord(rpPkg::READ, 5));
      checkAll();
      pulses(5);
      waitReady();
      checkAll();
      writeReg(rpPkg::RPCS, cmdWord(rpPkg::DRIVECLEAR, 0));
      writeReg(rpPkg::RPCS, cmdWord(rpPkg::READ, 0));
      checkAll();

      // Off the last cylinder
      setAddress(20, 18, 410);
      runRead(4);
      checkAll();
      writeReg(rpPkg::RPCS, cmdWord(rpPkg::DRIVECLEAR, 0));
      checkAll();

      // PRESET, then clr in the middle of a transfer
      setAddress(int'(randBits(8) % 22), int'(randBits(8) % 19), int'(randBits(10) % 411));
      writeReg(rpPkg::RPCS, cmdWord(rpPkg::PRESET, 0));
      // Preset strobe zeroes the address one edge later
      idleCycle();
      checkAll();
      setAddress(7, 9, 222);
      writeReg(rpPkg::RPCS, cmdWord(rpPkg::READ, 12));
      pulses(4);
      clrPulse();
      checkAll();

      finishRun();
   end

endmodule

//--- bench/rpDrive_assertions.sv
//////////////////////////////////////////////////
// RP drive controller assertions
// Bound into the controller, checks strobes and
// the transfer FSM exit
//////////////////////////////////////////////////

module rpDrive_assertions (
   input logic       clk,
   input logic       rst,
   input logic       clr,
   input logic       incSect,
   input logic       busy,
   input logic       ready,
   input logic       preset,
   input logic [7:0] count
);

   // Media pulses only reach the address with sectors left to go
   incSectBusy: assert property (@(posedge clk) disable iff (rst)
                                 incSect |-> busy && (count != 8'd0))
      else $error("incSect seen with no transfer in progress");

   // Single cycle preset strobe
   presetOneCycle: assert property (@(posedge clk) disable iff (rst) preset |=> !preset)
      else $error("preset held longer than one cycle");

   // Ready comes back only on clr or the last sector
   readyReturn: assert property (@(posedge clk) disable iff (rst)
                                 $rose(ready) |->
                                    $past(clr) || ($past(incSect) && ($past(count) == 8'd1)))
      else $error("ready returned without clr or last sector");

endmodule

bind rpDriveCtrl rpDrive_assertions u_rpDriveAssertions (
   .clk     (clk),
   .rst     (rst),
   .clr     (clr),
   .incSect (incSect),
   .busy    (busy),
   .ready   (ready),
   .preset  (preset),
   .count   (count)
);

//--- logic/rpCylAddr.sv
//////////////////////////////////////////////////
// RP desired cylinder register
// Loads from the bus while ready, steps on the
// track carry and flags a wrap past the last one
//////////////////////////////////////////////////

module rpCylAddr #(
   parameter int lastCyl = rpPkg::rpDefLastCyl
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clr,
   input  logic                          preset,
   input  logic                          wrEn,
   input  logic [rpPkg::rpDataWidth-1:0] wrData,
   input  logic                          ready,
   input  logic                          cylCarry,
   output logic [9:0]                    cylinder,
   output logic                          cylOverflow
);

   logic cylAtLast;
   logic zeroCyl;
   logic loadCyl;
   logic stepCyl;

   assign cylAtLast = (cylinder == 10'(lastCyl));
   assign zeroCyl   = clr | preset;
   assign loadCyl   = wrEn & ready;
   // Clear and load both win over a carry
   assign stepCyl   = cylCarry & ~zeroCyl & ~loadCyl;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         cylinder <= '0;
      else if (zeroCyl)
         cylinder <= '0;
      else if (loadCyl)
         cylinder <= wrData[9:0];
      else if (stepCyl)
         cylinder <= cylAtLast ? 10'd0 : cylinder + 10'd1;
   end

   // Ran off the end of the disk
   assign cylOverflow = stepCyl & cylAtLast;

endmodule

//--- logic/rpDiskAddr.sv
//////////////////////////////////////////////////
// RP sector/track address register
// Loads from the bus while ready, counts sectors,
// wraps into track and carries out to cylinder
//////////////////////////////////////////////////

module rpDiskAddr #(
   parameter int lastSect  = rpPkg::rpDefLastSect,
   parameter int lastTrack = rpPkg::rpDefLastTrack
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clr,
   input  logic                          preset,
   input  logic                          wrEn,
   input  logic [rpPkg::rpDataWidth-1:0] wrData,
   input  logic                          ready,
   input  logic                          incSect,
   output logic [5:0]                    sector,
   output logic [5:0]                    track,
   output logic                          cylCarry
);

   logic sectAtLast;
   logic trackAtLast;
   logic zeroAddr;
   logic loadAddr;

   assign sectAtLast  = (sector == 6'(lastSect));
   assign trackAtLast = (track == 6'(lastTrack));
   assign zeroAddr    = clr | preset;
   // Host load only honoured while the drive is idle
   assign loadAddr    = wrEn & ready;

   //////////////////////////////////////////////////
   // Sector counter
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         sector <= '0;
      else if (zeroAddr)
         sector <= '0;
      else if (loadAddr)
         sector <= wrData[5:0];
      else if (incSect)
         sector <= sectAtLast ? 6'd0 : sector + 6'd1;
   end

   //////////////////////////////////////////////////
   // Track counter
   //////////////////////////////////////////////////

   // Advances only on a sector wrap
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         track <= '0;
      else if (zeroAddr)
         track <= '0;
      else if (loadAddr)
         track <= wrData[13:8];
      else if (incSect & sectAtLast)
         track <= trackAtLast ? 6'd0 : track + 6'd1;
   end

   // Carry when sector and track both wrap, suppressed if overridden
   assign cylCarry = incSect & sectAtLast & trackAtLast & ~zeroAddr & ~loadAddr;

endmodule

//--- logic/rpDrive.sv
//////////////////////////////////////////////////
// RP drive register file, top level
// Register bus decode, read multiplexer and the
// controller and address register instances
//////////////////////////////////////////////////

module rpDrive #(
   parameter int lastSect  = rpPkg::rpDefLastSect,
   parameter int lastTrack = rpPkg::rpDefLastTrack,
   parameter int lastCyl   = rpPkg::rpDefLastCyl
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clr,
   input  logic                          wrStrobe,
   input  rpPkg::rpRegSel_e              wrSel,
   input  logic [rpPkg::rpDataWidth-1:0] wrData,
   input  rpPkg::rpRegSel_e              rdSel,
   output logic [15:0]                   rdData,
   input  logic                          sectorDone
);

   logic             cmdWr;
   logic             daWr;
   logic             dcWr;
   logic             ready;
   logic             preset;
   logic             incSect;
   logic             cylCarry;
   logic             cylOverflow;
   logic [5:0]       sector;
   logic [5:0]       track;
   logic [9:0]       cylinder;
   rpPkg::rpStatus_t status;

   // Per register write enables, RPDS writes go nowhere
   assign cmdWr = wrStrobe & (wrSel == rpPkg::RPCS);
   assign daWr  = wrStrobe & (wrSel == rpPkg::RPDA);
   assign dcWr  = wrStrobe & (wrSel == rpPkg::RPDC);

   rpDriveCtrl u_rpDriveCtrl (
      .clk         (clk),
      .rst         (rst),
      .clr         (clr),
      .cmdWr       (cmdWr),
      .cmdData     (wrData),
      .sectorDone  (sectorDone),
      .cylOverflow (cylOverflow),
      .status      (status),
      .ready       (ready),
      .preset      (preset),
      .incSect     (incSect)
   );

   rpDiskAddr #(
      .lastSect  (lastSect),
      .lastTrack (lastTrack)
   ) u_rpDiskAddr (
      .clk      (clk),
      .rst      (rst),
      .clr      (clr),
      .preset   (preset),
      .wrEn     (daWr),
      .wrData   (wrData),
      .ready    (ready),
      .incSect  (incSect),
      .sector   (sector),
      .track    (track),
      .cylCarry (cylCarry)
   );

   rpCylAddr #(
      .lastCyl (lastCyl)
   ) u_rpCylAddr (
      .clk         (clk),
      .rst         (rst),
      .clr         (clr),
      .preset      (preset),
      .wrEn        (dcWr),
      .wrData      (wrData),
      .ready       (ready),
      .cylCarry    (cylCarry),
      .cylinder    (cylinder),
      .cylOverflow (cylOverflow)
   );

   //////////////////////////////////////////////////
   // Read multiplexer
   //////////////////////////////////////////////////

   always_comb
   begin
      case (rdSel)
         // Track in the upper byte, sector in the lower
         rpPkg::RPDA: rdData = {2'b00, track, 2'b00, sector};
         rpPkg::RPDC: rdData = {6'd0, cylinder};
         rpPkg::RPDS: rdData = {12'd0, status};
         default:     rdData = 16'd0;
      endcase
   end

endmodule

//--- logic/rpDriveCtrl.sv
//////////////////////////////////////////////////
// RP drive command and status controller
// Decodes host commands, runs the transfer FSM,
// counts sectors and keeps the error bits
//////////////////////////////////////////////////

module rpDriveCtrl (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clr,
   input  logic                          cmdWr,
   input  logic [rpPkg::rpDataWidth-1:0] cmdData,
   input  logic                          sectorDone,
   input  logic                          cylOverflow,
   output rpPkg::rpStatus_t              status,
   output logic                          ready,
   output logic                          preset,
   output logic                          incSect
);

   typedef enum logic {
      IDLE,
      XFER
   } ctrlState_e;

   ctrlState_e    state;
   logic [7:0]    count;
   logic          busy;
   logic          lastSectErr;
   logic          opErr;
   rpPkg::rpCmd_t cmd;
   logic          isRead;
   logic          isPreset;
   logic          isClear;
   logic          badRead;

   //////////////////////////////////////////////////
   // Command decode
   //////////////////////////////////////////////////

   assign cmd      = rpPkg::rpCmd_t'(cmdData[9:0]);
   assign isRead   = cmdWr & (cmd.opcode == rpPkg::READ);
   assign isPreset = cmdWr & (cmd.opcode == rpPkg::PRESET);
   assign isClear  = cmdWr & (cmd.opcode == rpPkg::DRIVECLEAR);

   // Read while busy, or a read of nothing
   assign badRead  = isRead & (busy | (cmd.count == 8'd0));

   assign busy    = (state == XFER);
   assign ready   = (state == IDLE);

   // Media pulses only count during a transfer
   assign incSect = sectorDone & busy;

   //////////////////////////////////////////////////
   // Transfer FSM and sector count
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= IDLE;
         count <= '0;
      end
      else if (clr)
      begin
         state <= IDLE;
         count <= '0;
      end
      else if (isRead & ~badRead)
      begin
         // Start of transfer, only reachable from IDLE
         state <= XFER;
         count <= cmd.count;
      end
      else if (incSect)
      begin
         count <= count - 8'd1;
         // Last sector returns to idle on the same edge
         if (count == 8'd1)
            state <= IDLE;
      end
   end

   //////////////////////////////////////////////////
   // Error bits
   //////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         lastSectErr <= 1'b0;
         opErr       <= 1'b0;
      end
      else if (clr | isClear)
      begin
         lastSectErr <= 1'b0;
         opErr       <= 1'b0;
      end
      else
      begin
         if (cylOverflow)
            lastSectErr <= 1'b1;
         if (badRead)
            opErr <= 1'b1;
      end
   end

   // Preset strobe to the address registers, one cycle after the command
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         preset <= 1'b0;
      else if (clr)
         preset <= 1'b0;
      else
         preset <= isPreset;
   end

   assign status = '{
      ready:       ready,
      busy:        busy,
      lastSectErr: lastSectErr,
      opErr:       opErr
   };

endmodule

//--- logic/rpPkg.sv
//////////////////////////////////////////////////
// RP drive shared definitions
// Register selects, command codes, status and
// command layouts, default drive geometry
//////////////////////////////////////////////////

package rpPkg;

   // Host bus data width
   localparam int rpDataWidth = 36;

   // Default geometry, highest sector, track and cylinder numbers
   localparam int rpDefLastSect  = 21;
   localparam int rpDefLastTrack = 18;
   localparam int rpDefLastCyl   = 410;

   //////////////////////////////////////////////////
   // Register selects
   //////////////////////////////////////////////////

   // RPCS  command, reads as zero
   // RPDA  sector in bits 5:0, track in bits 13:8
   // RPDC  cylinder in bits 9:0
   // RPDS  status in bits 3:0
   typedef enum logic [1:0] {
      RPCS,
      RPDA,
      RPDC,
      RPDS
   } rpRegSel_e;

   // Command codes, bits 9:8 of an RPCS write
   typedef enum logic [1:0] {
      NOP,
      PRESET,
      READ,
      DRIVECLEAR
   } rpOpcode_e;

   // Drive status, low nibble of RPDS
   typedef struct packed {
      logic ready;
      logic busy;
      logic lastSectErr;
      logic opErr;
   } rpStatus_t;

   // Command word, count is the sector count in bits 7:0
   typedef struct packed {
      rpOpcode_e  opcode;
      logic [7:0] count;
   } rpCmd_t;

endpackage

//--- tb.f
logic/rpPkg.sv
logic/rpDiskAddr.sv
logic/rpCylAddr.sv
logic/rpDriveCtrl.sv
logic/rpDrive.sv
bench/rpDrive_assertions.sv
bench/rpDriveTb.sv
